/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := draw_top_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Everything OK

SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/draw_top_asserts.sv */
// bound checks on draw pixel writes and the filler done pulse
// one copy sits in the framebuffer, one in the rectangle filler
`timescale 1ns/1ps

module draw_top_asserts (
    input logic clk_100m,
    input logic rst_n,
    input logic we,          // pixel write this cycle
    input logic gate,        // write allowed this cycle
    input logic done         // end of shape pulse, tied low where absent
);

    // a write needs the gate open in the same cycle
    write_gated: assert property (
        @(posedge clk_100m) disable iff (!rst_n) we |-> gate
    ) else $error("pixel write while writes were not allowed");

    // done only right after the last pixel of an active shape
    done_after_write: assert property (
        @(posedge clk_100m) disable iff (!rst_n) done |-> $past(we)
    ) else $error("done pulse without a shape being drawn");

endmodule

// no draw write while clearing or reading
bind framebuffer draw_top_asserts fb_checks_i (
    .clk_100m (clk_100m),
    .rst_n    (rst_n),
    .we       (wr.we),
    .gate     (!busy),
    .done     (1'b0)
);

// writes only under oe, done only after a pixel
bind rect_fill_drawer draw_top_asserts fill_checks_i (
    .clk_100m (clk_100m),
    .rst_n    (rst_n),
    .we       (px.we),
    .gate     (oe),
    .done     (done)
);

/* bench/draw_top_tb.sv */
// testbench for the drawing subsystem
// frame strobes and random reads while drawing, then a full raster check
`timescale 1ns/1ps

module draw_top_tb import draw_pkg::*, fb_pkg::*; ();

    localparam int RESET_CYC    = 3;                 // cycles with rst_n low
    localparam int FRAME_PERIOD = 400;               // cycles between strobes
    localparam int READ_START   = FB_DEPTH + 2;      // clear sweep is over by then
    // reset, clear, 3 wait frames, 9 drawing frames and the scan come to ~10,700
    localparam int TIMEOUT_CYC  = 20000;

    logic   clk_100m;
    logic   rst_n;
    logic   frame;
    logic   rd_en;
    coord_t rd_x;
    coord_t rd_y;
    cidx_t  rd_cidx;
    logic   drawing;
    logic   all_done;

    cidx_t       model_img [FB_HEIGHT][FB_WIDTH];  // expected final picture
    logic [31:0] lcg_state;
    int          stim_cyc = 0;       // cycles since reset release
    int          tmo_cyc = 0;
    logic        scan_go = 1'b0;     // all shapes drawn, scan may start
    int          frames_seen = 0;
    int          frame_pix = 0;      // drawing cycles in the current frame
    int          drawn_total = 0;
    logic        pend_valid = 1'b0;  // read issued last cycle
    int          pend_x = 0;
    int          pend_y = 0;
    int          pend_phase = 0;     // 0 before drawing, 1 drawing, 2 finished

    draw_top draw_top_i (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .frame    (frame),
        .rd_en    (rd_en),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_cidx  (rd_cidx),
        .drawing  (drawing),
        .all_done (all_done)
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;  // 100 MHz
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // blank picture, then shapes 0 to 4, later ones on top
    task automatic paint_model();
        int x_left;
        int y_top;
        for (int y = 0; y < FB_HEIGHT; y++)
            for (int x = 0; x < FB_WIDTH; x++)
                model_img[y][x] = '0;
        for (int s = 0; s < SHAPE_CNT; s++) begin
            x_left = RECT_X0 + RECT_STEP * s;
            y_top  = RECT_Y0 + RECT_STEP * s;
            for (int y = y_top; y < y_top + RECT_H; y++)
                for (int x = x_left; x < x_left + RECT_W; x++)
                    model_img[y][x] = cidx_t'(s + 1);  // colour 0 stays black
        end
    endtask

    // frames start after the clear sweep, so the wait is seen with reads going
    task automatic drive_frame();
        stim_cyc++;
        frame <= (stim_cyc > FB_DEPTH) &&
                 ((stim_cyc - FB_DEPTH) % FRAME_PERIOD == 0);  // one cycle wide
    endtask

    task automatic issue_random_read();
        lcg_state = lcg_next(lcg_state);
        rd_en <= (lcg_state[31:30] == 2'b00);     // about one cycle in four
        rd_x  <= coord_t'(lcg_state[21:16]);      // 0 to 63
        rd_y  <= coord_t'(int'(lcg_state[15:8]) % FB_HEIGHT);
    endtask

    // stimulus, all inputs change on the rising edge
    initial begin
        rst_n <= 1'b0;
        frame <= 1'b0;
        rd_en <= 1'b0;
        rd_x  <= '0;
        rd_y  <= '0;
        lcg_state = 32'hd153_499d;
        paint_model();
        repeat (RESET_CYC) @(posedge clk_100m);
        rst_n <= 1'b1;
        while (!scan_go) begin
            @(posedge clk_100m);
            drive_frame();
            if (stim_cyc > READ_START) issue_random_read();
        end
        for (int i = 0; i < FB_DEPTH; i++) begin
            @(posedge clk_100m);
            drive_frame();
            rd_en <= 1'b1;                            // raster scan, row by row
            rd_x  <= coord_t'(i % FB_WIDTH);
            rd_y  <= coord_t'(i / FB_WIDTH);
        end
        @(posedge clk_100m);
        rd_en <= 1'b0;
        @(posedge clk_100m);                          // last result checked by now
        $display("Everything OK");
        $finish;
    end

    // result of the read issued one cycle earlier
    task automatic check_read();
        cidx_t exp_cidx;
        exp_cidx = model_img[pend_y][pend_x];
        case (pend_phase)
            0: assert (rd_cidx == '0) else fail_now($sformatf(
                "mismatch rd_cidx at (%0d,%0d) before drawing: got 0x%0h expected 0x0",
                pend_x, pend_y, rd_cidx));
            1: assert (int'(rd_cidx) <= SHAPE_CNT) else fail_now($sformatf(
                "mismatch rd_cidx at (%0d,%0d): got 0x%0h outside 0x0 to 0x%0h",
                pend_x, pend_y, rd_cidx, SHAPE_CNT));
            default: assert (rd_cidx == exp_cidx) else fail_now($sformatf(
                "mismatch rd_cidx at (%0d,%0d): got 0x%0h expected 0x%0h",
                pend_x, pend_y, rd_cidx, exp_cidx));
        endcase
    endtask

    task automatic track_drawing();
        assert (!drawing || frames_seen >= FRAME_WAIT)
            else fail_now("drawing started before the frame wait was over");
        assert (!(drawing && scan_go))
            else fail_now("a pixel was drawn after all_done");
        if (frame) begin
            frames_seen++;
            frame_pix = 0;                            // strobe cycle opens the frame
        end
        if (drawing) begin
            frame_pix++;
            drawn_total++;
        end
        assert (frame_pix <= PIX_FRAME) else fail_now($sformatf(
            "mismatch frame_pix: got 0x%0h above limit 0x%0h", frame_pix, PIX_FRAME));
        if (all_done && !scan_go) begin
            assert (drawn_total == SHAPE_CNT * RECT_W * RECT_H) else fail_now($sformatf(
                "mismatch drawn pixels at all_done: got 0x%0h expected 0x%0h",
                drawn_total, SHAPE_CNT * RECT_W * RECT_H));
            scan_go = 1'b1;
        end
    endtask

    // checks on the falling edge, away from input changes
    always @(negedge clk_100m) begin
        if (rst_n) begin
            if (pend_valid) check_read();
            pend_valid = rd_en;
            pend_x     = int'(rd_x);
            pend_y     = int'(rd_y);
            pend_phase = all_done ? 2 : ((drawn_total == 0) ? 0 : 1);
            track_drawing();
        end
    end

    always @(posedge clk_100m) begin
        tmo_cyc++;
        if (tmo_cyc >= TIMEOUT_CYC)
            fail_now("timeout: drawing and the raster scan did not finish in time");
    end

endmodule

/* source/draw_if.sv */
// draw pixel bus from the rectangle filler to the framebuffer
// one write per cycle with we high, no acknowledge
`timescale 1ns/1ps

interface draw_if import draw_pkg::*, fb_pkg::*; ();

    logic   we;     // write strobe, one pixel per cycle
    coord_t x;      // pixel column
    coord_t y;      // pixel row
    cidx_t  cidx;   // colour of the pixel

    // filler side, colour comes from the sequencer
    modport source (
        output we, x, y
    );

    // framebuffer side
    modport sink (
        input we, x, y, cidx
    );

endinterface

/* source/draw_pacer.sv */
// drawing pacer
// waits a few frames, then grants a limited pixel budget per frame
`timescale 1ns/1ps

module draw_pacer import draw_pkg::*; (
    input  logic clk_100m,
    input  logic rst_n,
    input  logic frame,      // frame strobe
    input  logic busy,       // framebuffer cannot take a write
    output logic oe          // filler may draw one pixel
);

    typedef logic [$clog2(FRAME_WAIT + 1)-1:0] wait_cnt_t;
    typedef logic [$clog2(PIX_FRAME + 1)-1:0] pix_cnt_t;

    wait_cnt_t wait_cnt;     // frames seen, saturates
    pix_cnt_t  pix_cnt;      // enables given this frame
    logic      wait_over;
    logic      budget_left;

    assign wait_over   = (wait_cnt == wait_cnt_t'(FRAME_WAIT));
    assign budget_left = (pix_cnt < pix_cnt_t'(PIX_FRAME));

    // one enable per cycle while allowed
    assign oe = wait_over && budget_left && !busy;

    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            pix_cnt  <= '0;
        end else begin
            if (frame && !wait_over) begin
                wait_cnt <= wait_cnt + wait_cnt_t'(1);
            end
            // enable on the strobe cycle counts towards the new frame
            if (frame) begin
                pix_cnt <= pix_cnt_t'(oe);
            end else if (oe) begin
                pix_cnt <= pix_cnt + pix_cnt_t'(1);
            end
        end
    end

endmodule

/* source/draw_pkg.sv */
// drawing package for the shape sequencer, pacer and rectangle filler
// holds coordinate type, rectangle geometry and drawing speed limits
package draw_pkg;

    // signed so that shapes may start off screen
    typedef logic signed [15:0] coord_t;        // screen coordinate

    localparam int SHAPE_CNT = 5;               // rectangles in the sequence
    typedef logic [2:0] shape_id_t;             // index into the sequence

    // shape 0 position and size
    localparam int RECT_X0 = 8;                 // left edge
    localparam int RECT_Y0 = 4;                 // top edge
    localparam int RECT_W = 20;                 // width in pixels
    localparam int RECT_H = 16;                 // height in pixels

    // each later shape moves down and right by this much
    localparam int RECT_STEP = 4;               // diagonal step per shape

    // drawing speed
    localparam int FRAME_WAIT = 3;              // frames to wait before drawing
    localparam int PIX_FRAME = 200;             // pixel enables per frame

    // handy totals
    localparam int RECT_PIX = RECT_W * RECT_H;  // pixels per rectangle
    localparam int TOTAL_PIX = SHAPE_CNT * RECT_PIX;  // pixels in the sequence

endpackage

/* source/draw_top.sv */
// drawing subsystem top level
// sequencer, pacer and rectangle filler paint into the framebuffer
`timescale 1ns/1ps

module draw_top import draw_pkg::*, fb_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   frame,        // one-cycle frame strobe
    input  logic   rd_en,        // pixel read request
    input  coord_t rd_x,
    input  coord_t rd_y,
    output cidx_t  rd_cidx,      // read data, one cycle later
    output logic   drawing,      // pixel written this cycle
    output logic   all_done      // every shape painted
);

    logic   draw_start;          // sequencer to filler
    logic   draw_done;           // filler to sequencer
    coord_t vx0;                 // shape corners
    coord_t vy0;
    coord_t vx1;
    coord_t vy1;
    cidx_t  shape_cidx;          // shape colour
    logic   fb_busy;
    logic   draw_oe;

    draw_if draw_bus ();

    assign draw_bus.cidx = shape_cidx;   // colour rides with each write
    assign drawing       = draw_bus.we;

    shape_sequencer shape_sequencer_i (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .frame    (frame),
        .done     (draw_done),
        .start    (draw_start),
        .x0       (vx0),
        .y0       (vy0),
        .x1       (vx1),
        .y1       (vy1),
        .cidx     (shape_cidx),
        .all_done (all_done)
    );

    draw_pacer draw_pacer_i (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .frame    (frame),
        .busy     (fb_busy),
        .oe       (draw_oe)
    );

    rect_fill_drawer rect_fill_drawer_i (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .start    (draw_start),
        .oe       (draw_oe),
        .x0       (vx0),
        .y0       (vy0),
        .x1       (vx1),
        .y1       (vy1),
        .px       (draw_bus),
        .done     (draw_done)
    );

    framebuffer framebuffer_i (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .wr       (draw_bus),
        .rd_en    (rd_en),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .rd_cidx  (rd_cidx),
        .busy     (fb_busy)
    );

endmodule

/* source/fb_pkg.sv */
// framebuffer package
// geometry, colour index and address types of the pixel memory
package fb_pkg;

    // small buffer to keep simulation short
    localparam int FB_WIDTH = 64;                   // pixels per row
    localparam int FB_HEIGHT = 48;                  // rows
    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT;  // 3072 pixels

    // colour index into an external palette, 0 is black
    typedef logic [3:0] cidx_t;                     // colour index

    // row-major address: y * FB_WIDTH + x
    typedef logic [11:0] fb_addr_t;                 // linear pixel address

endpackage

/* source/framebuffer.sv */
// framebuffer
// colour index memory, cleared after reset, with draw writes and pixel reads
`timescale 1ns/1ps

module framebuffer import draw_pkg::*, fb_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    draw_if.sink   wr,           // draw pixel writes
    input  logic   rd_en,        // read request
    input  coord_t rd_x,
    input  coord_t rd_y,
    output cidx_t  rd_cidx,      // valid the cycle after rd_en
    output logic   busy          // no write allowed this cycle
);

    cidx_t    mem [FB_DEPTH];
    fb_addr_t clr_addr;          // clear sweep position
    logic     clearing;
    fb_addr_t wr_addr;
    fb_addr_t rd_addr;

    // row-major, width is a power of two
    function automatic fb_addr_t to_addr(coord_t x, coord_t y);
        return fb_addr_t'(int'(y) * FB_WIDTH + int'(x));
    endfunction

    assign wr_addr = to_addr(wr.x, wr.y);
    assign rd_addr = to_addr(rd_x, rd_y);

    // reads win over draw writes
    assign busy = clearing || rd_en;

    // clear sweep, one address per cycle
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + fb_addr_t'(1);
            if (clr_addr == fb_addr_t'(FB_DEPTH - 1)) clearing <= 1'b0;
        end
    end

    // memory port
    always_ff @(posedge clk_100m) begin
        if (clearing) begin
            mem[clr_addr] <= '0;                 // black
        end else if (wr.we) begin
            mem[wr_addr] <= wr.cidx;
        end
        if (rd_en) rd_cidx <= mem[rd_addr];
    end

endmodule

/* source/rect_fill_drawer.sv */
// filled rectangle drawer
// walks each row left to right then steps down, one pixel per enabled cycle
`timescale 1ns/1ps

module rect_fill_drawer import draw_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   start,        // begin a new rectangle
    input  logic   oe,           // may present a pixel this cycle
    input  coord_t x0,           // top-left corner
    input  coord_t y0,
    input  coord_t x1,           // bottom-right corner
    input  coord_t y1,
    draw_if.source px,           // pixel writes
    output logic   done          // pulse after the last pixel
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DRAW,
        FIN
    } state_t;

    state_t state;
    coord_t x;                   // current column
    coord_t y;                   // current row
    coord_t x_left;              // row restart column
    coord_t x_right;             // last column
    coord_t y_bottom;            // last row
    logic   step;                // pixel consumed this cycle
    logic   row_end;
    logic   last_pix;

    assign step     = (state == DRAW) && oe;
    assign row_end  = (x == x_right);
    assign last_pix = row_end && (y == y_bottom);

    // control
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (start) state <= LOAD;
                LOAD: state <= DRAW;                 // corners taken here
                DRAW: if (step && last_pix) state <= FIN;
                default: state <= start ? LOAD : IDLE;  // done cycle
            endcase
        end
    end

    // position, held while oe is low
    always_ff @(posedge clk_100m) begin
        if (state == LOAD) begin
            x        <= x0;
            y        <= y0;
            x_left   <= x0;
            x_right  <= x1;
            y_bottom <= y1;
        end else if (step && !last_pix) begin
            if (row_end) begin
                x <= x_left;                         // next row
                y <= y + coord_t'(1);
            end else begin
                x <= x + coord_t'(1);
            end
        end
    end

    assign px.we = step;         // write lands with the presented pixel
    assign px.x  = x;
    assign px.y  = y;
    assign done  = (state == FIN);

endmodule

/* source/shape_sequencer.sv */
// shape sequencer
// steps through the rectangles, sets corners and colour, starts the filler
`timescale 1ns/1ps

module shape_sequencer import draw_pkg::*, fb_pkg::*; (
    input  logic      clk_100m,
    input  logic      rst_n,
    input  logic      frame,     // frame strobe
    input  logic      done,      // filler finished a shape
    output logic      start,     // filler start pulse
    output coord_t    x0,        // top-left corner
    output coord_t    y0,
    output coord_t    x1,        // bottom-right corner
    output coord_t    y1,
    output cidx_t     cidx,      // shape colour
    output logic      all_done   // every shape drawn
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        DRAW,
        FINISHED
    } state_t;

    state_t    state;
    shape_id_t shape_id;         // shape being drawn
    coord_t    offset;           // diagonal shift of this shape

    assign offset = coord_t'(RECT_STEP * int'(shape_id));

    // control
    always_ff @(posedge clk_100m or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            shape_id <= '0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;                       // pulse by default
            case (state)
                IDLE: begin
                    if (frame) state <= SETUP;   // first frame after reset
                end
                SETUP: begin
                    start <= 1'b1;               // corners valid with start
                    state <= DRAW;
                end
                DRAW: begin
                    if (done) begin
                        if (shape_id == shape_id_t'(SHAPE_CNT - 1)) begin
                            state <= FINISHED;
                        end else begin
                            shape_id <= shape_id + 1'b1;
                            state    <= SETUP;
                        end
                    end
                end
                default: state <= FINISHED;      // stays here until reset
            endcase
        end
    end

    // corners and colour, loaded in setup
    always_ff @(posedge clk_100m) begin
        if (state == SETUP) begin
            x0   <= coord_t'(RECT_X0) + offset;
            y0   <= coord_t'(RECT_Y0) + offset;
            x1   <= coord_t'(RECT_X0 + RECT_W - 1) + offset;
            y1   <= coord_t'(RECT_Y0 + RECT_H - 1) + offset;
            cidx <= cidx_t'(shape_id) + cidx_t'(1);  // skip black
        end
    end

    assign all_done = (state == FINISHED);

endmodule

/* vlog.f */
source/draw_pkg.sv
source/fb_pkg.sv
source/draw_if.sv
source/shape_sequencer.sv
source/draw_pacer.sv
source/rect_fill_drawer.sv
source/framebuffer.sv
source/draw_top.sv
bench/draw_top_asserts.sv
bench/draw_top_tb.sv
